/* qa_rd.f */
design/qa_rd_types_pkg.sv
design/qa_rd_cfg_pkg.sv
design/qa_rd_req_if.sv
design/qa_rd_csr.sv
design/qa_rd_stream_gen.sv
design/qa_rd_issue_ctrl.sv
design/qa_rd_arbiter.sv
design/qa_rd_top.sv
bench/qa_rd_tb.sv

/* Bender.yml */
package:
  name: qa_rd

sources:
  # Packages first, then the interface, then the modules that use them
  - design/qa_rd_types_pkg.sv
  - design/qa_rd_cfg_pkg.sv
  - design/qa_rd_req_if.sv
  - design/qa_rd_csr.sv
  - design/qa_rd_stream_gen.sv
  - design/qa_rd_issue_ctrl.sv
  - design/qa_rd_arbiter.sv
  - design/qa_rd_top.sv
  - target: test
    files:
      - bench/qa_rd_tb.sv

/* bench/qa_rd_tb.sv */
// Self-checking testbench for the read-request path
// Random stream runs and almost-full bursts from a fixed-seed LCG, with every
// read request compared against a cycle model of the streams and arbiter
`default_nettype none

module qa_rd_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import qa_rd_types_pkg::*;
   import qa_rd_cfg_pkg::*;

   localparam int          HOLDOFF   = 2;
   localparam logic [31:0] SEED      = 32'h0e3692da;
   localparam int          MAX_COUNT = 40;
   localparam int          MAX_BURST = 6;
   localparam int          ROUNDS    = 12;
   // Every run the tests can start, plus the stall cycles that bursts can add
   localparam int MAX_LINES       = (ROUNDS + 4) * NUM_STREAMS * MAX_COUNT;
   localparam int HOLD_CYCLES     = MAX_LINES * HOLDOFF + ROUNDS * MAX_COUNT * MAX_BURST;
   localparam int WATCHDOG_CYCLES = 4 * (MAX_LINES + HOLD_CYCLES + 400);
   localparam int IDLE_LIMIT      = 16 * NUM_STREAMS * MAX_COUNT + 64;

   logic                   clk = 1'b0;
   logic                   reset_n;
   logic                   csr_write;
   csr_addr_t              csr_addr;
   csr_data_t              csr_data;
   logic                   rd_almostfull;
   logic                   rd_valid;
   line_addr_t             rd_addr;
   rd_tag_t                rd_tag;
   logic [NUM_STREAMS-1:0] stream_busy;

   // Cycle model of the registered state seen from outside
   logic                   m_enable;
   logic                   m_favor_writer;
   logic [NUM_STREAMS-1:0] m_start;
   logic [NUM_STREAMS-1:0] m_busy;
   logic                   m_valid;
   line_addr_t             m_addr;
   rd_tag_t                m_tag;
   int                     m_gap;
   line_addr_t             m_base  [NUM_STREAMS];
   int                     m_count [NUM_STREAMS];
   line_addr_t             m_cur   [NUM_STREAMS];
   int                     m_rem   [NUM_STREAMS];
   logic [5:0]             m_seq   [NUM_STREAMS];

   int          issued [NUM_STREAMS];
   int          af_left;
   logic [31:0] rng_state;

   qa_rd_top #(.HOLDOFF(HOLDOFF)) DUT (
      .clk(clk), .reset_n(reset_n),
      .csr_write(csr_write), .csr_addr(csr_addr), .csr_data(csr_data),
      .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_tag(rd_tag),
      .rd_almostfull(rd_almostfull), .stream_busy(stream_busy)
   );

   initial begin
      forever #2 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      fail_now("watchdog expired before the tests finished");
   end

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // Upper bits of the LCG are the better distributed ones
   function automatic int rand_below(input int n);
      return int'((lcg_next() >> 8) % n);
   endfunction

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1, "stopping at the first error");
   endtask

   // Advances the model over the clock edge just taken, using the inputs the DUT sampled there
   task automatic model_step();
      logic [NUM_STREAMS-1:0] old_busy;
      int win;
      if (!reset_n) begin
         m_enable = 1'b0;
         m_favor_writer = 1'b0;
         m_start = '0;
         m_busy = '0;
         m_valid = 1'b0;
         m_gap = 1;
         for (int i = 0; i < NUM_STREAMS; i++) m_count[i] = 0;
         return;
      end
      old_busy = m_busy;
      win = -1;
      // Reader and writer take turns, status only gets the idle slots
      if (m_enable && m_gap == 0) begin
         if (m_busy[0] && m_busy[1]) win = m_favor_writer ? 1 : 0;
         else if (m_busy[0]) win = 0;
         else if (m_busy[1]) win = 1;
         else if (m_busy[2]) win = 2;
      end
      m_valid = (win >= 0);
      if (win >= 0) begin
         m_addr = m_cur[win];
         m_tag = {tag_id_t'(win), m_seq[win]};
         m_favor_writer = (win == 0);
         m_cur[win] = m_cur[win] + 1;
         m_seq[win] = m_seq[win] + 1;
         m_rem[win] = m_rem[win] - 1;
         if (m_rem[win] == 0) m_busy[win] = 1'b0;
      end
      // A start is dropped on a stream that was busy before this edge
      for (int i = 0; i < NUM_STREAMS; i++) begin
         if (m_start[i] && !old_busy[i]) begin
            m_cur[i] = m_base[i];
            m_rem[i] = m_count[i];
            m_seq[i] = '0;
            m_busy[i] = (m_count[i] != 0);
         end
      end
      m_start = '0;
      if (csr_write) begin
         if (csr_addr == CSR_ENABLE) m_enable = csr_data[0];
         if (csr_addr == CSR_START) m_start = csr_data[NUM_STREAMS-1:0];
         for (int i = 0; i < NUM_STREAMS; i++) begin
            if (csr_addr == 4 + 2 * i) m_base[i] = csr_data;
            if (csr_addr == 5 + 2 * i) m_count[i] = int'(csr_data[15:0]);
         end
      end
      // Issue stays shut while almost full is seen and HOLDOFF edges past it
      if (rd_almostfull) m_gap = HOLDOFF;
      else if (m_gap > 0) m_gap--;
   endtask

   // One clock cycle; outputs are checked on the falling edge, then inputs are driven
   task automatic tick();
      int id;
      @(negedge clk);
      model_step();
      assert (rd_valid === m_valid) else fail_now($sformatf(
         "mismatch at %0t: rd_valid expected %b got %b", $time, m_valid, rd_valid));
      if (m_valid) begin
         assert (rd_addr === m_addr) else fail_now($sformatf(
            "mismatch at %0t: rd_addr expected %h got %h", $time, m_addr, rd_addr));
         assert (rd_tag === m_tag) else fail_now($sformatf(
            "mismatch at %0t: rd_tag expected %h got %h", $time, m_tag, rd_tag));
      end
      assert (stream_busy === m_busy) else fail_now($sformatf(
         "mismatch at %0t: stream_busy expected %b got %b", $time, m_busy, stream_busy));
      id = int'(rd_tag[7:6]);
      if (rd_valid === 1'b1 && id < NUM_STREAMS) issued[id]++;
      csr_write = 1'b0;
      rd_almostfull = (af_left > 0);
      if (af_left > 0) af_left--;
   endtask

   task automatic csr_wr(input csr_addr_t addr, input csr_data_t data);
      tick();
      csr_write = 1'b1;
      csr_addr = addr;
      csr_data = data;
   endtask

   task automatic setup_stream(input int idx, input line_addr_t base, input int count);
      csr_wr(csr_addr_t'(4 + 2 * idx), base);
      csr_wr(csr_addr_t'(5 + 2 * idx), csr_data_t'(count));
   endtask

   // Runs until every stream is idle again, optionally with random almost-full bursts
   task automatic wait_idle(input bit with_af);
      int cycles;
      cycles = 0;
      repeat (2) tick();
      while (stream_busy != '0) begin
         if (with_af && af_left == 0 && rand_below(12) == 0) af_left = 1 + rand_below(MAX_BURST);
         tick();
         cycles++;
         assert (cycles <= IDLE_LIMIT) else fail_now("streams stayed busy far too long");
      end
      af_left = 0;
      tick();
   endtask

   task automatic check_issued(input int idx, input int expected);
      assert (issued[idx] == expected) else fail_now($sformatf(
         "mismatch at %0t: issued[%0d] expected %0d got %0d", $time, idx, expected, issued[idx]));
      issued[idx] = 0;
   endtask

   initial begin : main
      int cnt [NUM_STREAMS];
      logic [NUM_STREAMS-1:0] mask;
      rng_state = SEED;
      af_left = 0;
      reset_n = 1'b0;
      csr_write = 1'b0;
      csr_addr = '0;
      csr_data = '0;
      rd_almostfull = 1'b0;
      for (int i = 0; i < NUM_STREAMS; i++) issued[i] = 0;
      repeat (4) tick();
      reset_n = 1'b1;

      // Quiet after reset, and a stream started while disabled must wait
      tick();
      assert (rd_valid === 1'b0 && stream_busy === '0) else fail_now("activity right after reset");
      setup_stream(0, lcg_next(), 5);
      csr_wr(CSR_START, 32'h1);
      repeat (12) begin
         tick();
         assert (rd_valid === 1'b0) else fail_now("request issued before the enable bit was set");
      end
      csr_wr(CSR_ENABLE, 32'h1);
      wait_idle(1'b0);
      check_issued(0, 5);

      // Each stream on its own
      for (int s = 0; s < NUM_STREAMS; s++) begin
         cnt[s] = 1 + rand_below(MAX_COUNT);
         setup_stream(s, lcg_next(), cnt[s]);
         csr_wr(CSR_START, csr_data_t'(1 << s));
         wait_idle(1'b0);
         check_issued(s, cnt[s]);
      end

      // All three together, so the model sees the reader and writer alternate
      for (int s = 0; s < NUM_STREAMS; s++) begin
         cnt[s] = 10 + rand_below(MAX_COUNT - 9);
         setup_stream(s, lcg_next(), cnt[s]);
      end
      csr_wr(CSR_START, 32'h7);
      wait_idle(1'b0);
      for (int s = 0; s < NUM_STREAMS; s++) check_issued(s, cnt[s]);

      // Random runs under almost-full bursts, every line has to come out
      repeat (ROUNDS) begin
         mask = NUM_STREAMS'(1 + rand_below(7));
         for (int s = 0; s < NUM_STREAMS; s++) begin
            cnt[s] = rand_below(MAX_COUNT + 1);
            setup_stream(s, lcg_next(), cnt[s]);
         end
         csr_wr(CSR_START, csr_data_t'(mask));
         wait_idle(1'b1);
         for (int s = 0; s < NUM_STREAMS; s++) check_issued(s, mask[s] ? cnt[s] : 0);
      end

      // Pause mid-run, then poke a busy stream and a zero-length run
      setup_stream(0, lcg_next(), 30);
      setup_stream(1, lcg_next(), 30);
      csr_wr(CSR_START, 32'h3);
      repeat (8) tick();
      csr_wr(CSR_ENABLE, 32'h0);
      // A grant from the last enabled cycle may still be on its way out
      tick();
      repeat (10) begin
         tick();
         assert (rd_valid === 1'b0) else fail_now("request issued while the enable bit was clear");
      end
      setup_stream(0, lcg_next(), 3);
      setup_stream(2, lcg_next(), 0);
      csr_wr(CSR_START, 32'h5);
      repeat (4) tick();
      assert (stream_busy === 3'b011) else fail_now("ignored starts changed the busy streams");
      csr_wr(CSR_ENABLE, 32'h1);
      wait_idle(1'b1);
      check_issued(0, 30);
      check_issued(1, 30);
      check_issued(2, 0);

      tick();
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

/* design/qa_rd_top.sv */
// Top level of the read-request path
// Register block feeds three line-address streams and the read arbiter
// merges them onto the host read channel
`default_nettype none

module qa_rd_top #(
   parameter int HOLDOFF = 2
) (
   input  wire                                   clk,
   input  wire                                   reset_n,
   // Register write port
   input  wire                                   csr_write,
   input  wire qa_rd_types_pkg::csr_addr_t       csr_addr,
   input  wire qa_rd_types_pkg::csr_data_t       csr_data,
   // Host read-request channel
   output logic                                  rd_valid,
   output qa_rd_types_pkg::line_addr_t           rd_addr,
   output qa_rd_types_pkg::rd_tag_t              rd_tag,
   input  wire                                   rd_almostfull,
   // One bit per stream, high while a run is in progress
   output wire [qa_rd_cfg_pkg::NUM_STREAMS-1:0]  stream_busy
);

   import qa_rd_types_pkg::*;
   import qa_rd_cfg_pkg::*;

   logic                   enable;
   logic [NUM_STREAMS-1:0] start;
   line_addr_t             base  [NUM_STREAMS];
   line_count_t            count [NUM_STREAMS];

   // One request channel per stream
   qa_rd_req_if req_if [NUM_STREAMS] ();

   qa_rd_csr u_csr (
      .clk       (clk),
      .reset_n   (reset_n),
      .csr_write (csr_write),
      .csr_addr  (csr_addr),
      .csr_data  (csr_data),
      .enable    (enable),
      .start     (start),
      .base      (base),
      .count     (count)
   );

   // Stream index doubles as its role and its tag prefix
   for (genvar i = 0; i < NUM_STREAMS; i++) begin : g_stream
      qa_rd_stream_gen #(
         .STREAM_ID(stream_id_t'(i))
      ) u_stream (
         .clk     (clk),
         .reset_n (reset_n),
         .start   (start[i]),
         .base    (base[i]),
         .count   (count[i]),
         .req     (req_if[i]),
         .busy    (stream_busy[i])
      );
   end

   qa_rd_arbiter #(
      .HOLDOFF(HOLDOFF)
   ) u_arbiter (
      .clk           (clk),
      .reset_n       (reset_n),
      .enable        (enable),
      .req           (req_if),
      .rd_almostfull (rd_almostfull),
      .rd_valid      (rd_valid),
      .rd_addr       (rd_addr),
      .rd_tag        (rd_tag)
   );

endmodule

`default_nettype wire

/* design/qa_rd_arbiter.sv */
// Read arbiter for the host read-request channel
// Alternates between the frame reader and frame writer, lets the status
// stream in only when both are quiet, and registers the winner onto the channel
`default_nettype none

module qa_rd_arbiter #(
   parameter int HOLDOFF = 2
) (
   input  wire                         clk,
   input  wire                         reset_n,
   input  wire                         enable,
   qa_rd_req_if.arb                    req [qa_rd_cfg_pkg::NUM_STREAMS],
   input  wire                         rd_almostfull,
   output logic                        rd_valid,
   output qa_rd_types_pkg::line_addr_t rd_addr,
   output qa_rd_types_pkg::rd_tag_t    rd_tag
);

   import qa_rd_types_pkg::*;
   import qa_rd_cfg_pkg::*;

   localparam int READER = int'(STREAM_FRAME_READER);
   localparam int WRITER = int'(STREAM_FRAME_WRITER);
   localparam int STATUS = int'(STREAM_STATUS);

   typedef enum logic {favor_reader, favor_writer} favor_t;

   favor_t favor;
   favor_t favor_next;

   // Issue needs both room on the host channel and the enable bit
   logic cci_can_issue;
   logic can_issue;

   // Stream requests flattened out of the interface array
   logic [NUM_STREAMS-1:0] request;
   logic [NUM_STREAMS-1:0] grant;
   line_addr_t             req_addr [NUM_STREAMS];
   rd_tag_t                req_tag  [NUM_STREAMS];

   // Winner of this cycle
   line_addr_t sel_addr;
   rd_tag_t    sel_tag;

   qa_rd_issue_ctrl #(
      .HOLDOFF(HOLDOFF)
   ) u_issue_ctrl (
      .clk        (clk),
      .reset_n    (reset_n),
      .almostfull (rd_almostfull),
      .can_issue  (cci_can_issue)
   );

   assign can_issue = cci_can_issue && enable;

   for (genvar i = 0; i < NUM_STREAMS; i++) begin : g_port
      assign request[i]  = req[i].request;
      assign req_addr[i] = req[i].addr;
      assign req_tag[i]  = req[i].tag;
      assign req[i].grant = grant[i];
   end

   // Fixed priority with the reader and writer swapping on favor
   always_comb begin
      grant = '0;
      // Default to the reader so its path needs no extra mux leg
      sel_addr = req_addr[READER];
      sel_tag  = req_tag[READER];
      if (request[READER] && (favor == favor_reader || !request[WRITER])) begin
         grant[READER] = can_issue;
      end else if (request[WRITER]) begin
         grant[WRITER] = can_issue;
         sel_addr      = req_addr[WRITER];
         sel_tag       = req_tag[WRITER];
      end else if (request[STATUS]) begin
         grant[STATUS] = can_issue;
         sel_addr      = req_addr[STATUS];
         sel_tag       = req_tag[STATUS];
      end
   end

   // Favor only moves on a grant, so a stall keeps the turn where it was
   always_comb begin
      favor_next = favor;
      if (grant[READER]) begin
         favor_next = favor_writer;
      end else if (grant != '0) begin
         favor_next = favor_reader;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         favor    <= favor_reader;
         rd_valid <= 1'b0;
      end else begin
         favor    <= favor_next;
         rd_valid <= (grant != '0);
      end
   end

   // Address and tag only mean something alongside rd_valid
   always_ff @(posedge clk) begin
      rd_addr <= sel_addr;
      rd_tag  <= sel_tag;
   end

   // At most one stream wins, and only a stream that is asking
   a_grant_onehot : assert property (
      @(posedge clk) disable iff (!reset_n)
      $onehot0(grant) && ((grant & ~request) == '0)
   ) else $error("bad read grant %b for requests %b", grant, request);

endmodule

`default_nettype wire

/* design/qa_rd_issue_ctrl.sv */
// Issue throttle for the host read channel
// Holds can_issue low while almost full is reported and for HOLDOFF
// cycles after it falls, to cover requests still in flight
`default_nettype none

module qa_rd_issue_ctrl #(
   parameter int HOLDOFF = 2
) (
   input  wire  clk,
   input  wire  reset_n,
   input  wire  almostfull,
   output logic can_issue
);

   // Wide enough to hold HOLDOFF itself
   localparam int CNT_W = (HOLDOFF > 0) ? $clog2(HOLDOFF + 1) : 1;

   typedef enum logic {issue_open, issue_hold} issue_state_t;

   issue_state_t     state;
   logic [CNT_W-1:0] holdoff_cnt;

   // Reset lands in issue_hold with an empty counter, so issue opens
   // on the second cycle out of reset
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state       <= issue_hold;
         holdoff_cnt <= '0;
         can_issue   <= 1'b0;
      end else begin
         case (state)
            issue_open: begin
               if (almostfull) begin
                  state       <= issue_hold;
                  holdoff_cnt <= CNT_W'(HOLDOFF);
                  can_issue   <= 1'b0;
               end
            end
            issue_hold: begin
               // Every new almost-full sample restarts the window
               if (almostfull) begin
                  holdoff_cnt <= CNT_W'(HOLDOFF);
               end else if (holdoff_cnt > CNT_W'(1)) begin
                  holdoff_cnt <= holdoff_cnt - 1'b1;
               end else begin
                  state     <= issue_open;
                  can_issue <= 1'b1;
               end
            end
            default: state <= issue_hold;
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/qa_rd_stream_gen.sv */
// One line-address stream
// After a start it asks for count lines from base upward, one at a
// time, and tags each with its stream index and a sequence number
`default_nettype none

module qa_rd_stream_gen #(
   parameter qa_rd_cfg_pkg::stream_id_t STREAM_ID = qa_rd_cfg_pkg::STREAM_FRAME_READER
) (
   input  wire                               clk,
   input  wire                               reset_n,
   input  wire                               start,
   input  wire qa_rd_types_pkg::line_addr_t  base,
   input  wire qa_rd_types_pkg::line_count_t count,
   qa_rd_req_if.gen                          req,
   output logic                              busy
);

   import qa_rd_types_pkg::*;

   // Line currently on offer and what is left of the run
   line_addr_t  cur_addr;
   line_count_t remaining;
   tag_seq_t    seq;

   // A start only counts when the stream is idle
   logic load;
   assign load = start && !busy;

   // Busy is high from the cycle after the start strobe until the last
   // line is granted; a count of zero never raises it
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         busy <= 1'b0;
      end else if (load) begin
         busy <= (count != '0);
      end else if (req.grant && remaining == line_count_t'(1)) begin
         busy <= 1'b0;
      end
   end

   // Address, count and sequence step together on each grant
   always_ff @(posedge clk) begin
      if (load) begin
         cur_addr  <= base;
         remaining <= count;
         seq       <= '0;
      end else if (req.grant) begin
         cur_addr  <= cur_addr + 1'b1;
         remaining <= remaining - 1'b1;
         seq       <= seq + 1'b1;
      end
   end

   // There is always a request while the run is in progress
   assign req.request = busy;
   assign req.addr    = cur_addr;
   assign req.tag     = {tag_id_t'(STREAM_ID), seq};

   // The arbiter may leave a request waiting for many cycles under
   // almost full, and it must see the same line when it finally grants
   a_hold_until_grant : assert property (
      @(posedge clk) disable iff (!reset_n)
      req.request && !req.grant |=>
         req.request && $stable(req.addr) && $stable(req.tag)
   ) else $error("stream %0d changed its request before grant", STREAM_ID);

endmodule

`default_nettype wire

/* design/qa_rd_csr.sv */
// Write-only register block for the read-request path
// Holds the enable bit and each stream's base and count, and
// turns writes to the start register into one-cycle start strobes
`default_nettype none

module qa_rd_csr (
   input  wire                                 clk,
   input  wire                                 reset_n,
   input  wire                                 csr_write,
   input  wire qa_rd_types_pkg::csr_addr_t     csr_addr,
   input  wire qa_rd_types_pkg::csr_data_t     csr_data,
   output logic                                enable,
   output logic [qa_rd_cfg_pkg::NUM_STREAMS-1:0] start,
   output qa_rd_types_pkg::line_addr_t         base  [qa_rd_cfg_pkg::NUM_STREAMS],
   output qa_rd_types_pkg::line_count_t        count [qa_rd_cfg_pkg::NUM_STREAMS]
);

   import qa_rd_types_pkg::*;
   import qa_rd_cfg_pkg::*;

   // Enable and start strobes
   // A write at one edge shows up on start in the cycle right after it
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         enable <= 1'b0;
         start  <= '0;
      end else begin
         // Start bits are not stored, so they fall again after one cycle
         start <= '0;
         if (csr_write) begin
            if (csr_addr == CSR_ENABLE) begin
               enable <= csr_data[CSR_ENABLE_BIT];
            end
            if (csr_addr == CSR_START) begin
               start <= csr_data[NUM_STREAMS-1:0];
            end
         end
      end
   end

   // Per-stream setup registers
   for (genvar i = 0; i < NUM_STREAMS; i++) begin : g_stream
      localparam csr_addr_t BASE_ADDR  = csr_base_addr(i);
      localparam csr_addr_t COUNT_ADDR = csr_count_addr(i);

      // The base only matters once a start has loaded it
      always_ff @(posedge clk) begin
         if (csr_write && csr_addr == BASE_ADDR) begin
            base[i] <= csr_data[LINE_ADDR_W-1:0];
         end
      end

      // Count comes up as zero so that a start on a stream that was
      // never set up gives no requests
      always_ff @(posedge clk) begin
         if (!reset_n) begin
            count[i] <= '0;
         end else if (csr_write && csr_addr == COUNT_ADDR) begin
            count[i] <= csr_data[LINE_COUNT_W-1:0];
         end
      end
   end

endmodule

`default_nettype wire

/* design/qa_rd_req_if.sv */
// Request and grant between one line-address stream and the read arbiter
// The stream holds its request steady until grant comes back in the same cycle
`default_nettype none

interface qa_rd_req_if;

   import qa_rd_types_pkg::*;

   // Stream has a line waiting to be read
   logic       request;
   // Line address and tag of that waiting request
   line_addr_t addr;
   rd_tag_t    tag;
   // Arbiter took the request this cycle
   logic       grant;

   // Stream side
   modport gen (
      output request, addr, tag,
      input  grant
   );

   // Arbiter side
   modport arb (
      input  request, addr, tag,
      output grant
   );

endinterface

`default_nettype wire

/* design/qa_rd_cfg_pkg.sv */
// Register map, stream roles and stream count of the read-request path
// Software and the register block both follow this map
`default_nettype none

package qa_rd_cfg_pkg;

   // Fixed at three since the arbiter gives each role its own policy
   localparam int NUM_STREAMS = 3;

   // Stream roles, the value is also the index in the tag
   typedef enum logic [qa_rd_types_pkg::TAG_ID_W-1:0] {
      STREAM_FRAME_READER = 2'd0,
      STREAM_FRAME_WRITER = 2'd1,
      STREAM_STATUS       = 2'd2
   } stream_id_t;

   // Enable register, only bit 0 is stored
   localparam qa_rd_types_pkg::csr_addr_t CSR_ENABLE = 4'd0;
   localparam int CSR_ENABLE_BIT = 0;

   // Start register, one self-clearing strobe bit per stream
   localparam qa_rd_types_pkg::csr_addr_t CSR_START = 4'd1;

   // Per-stream setup, base and count interleaved in pairs
   localparam qa_rd_types_pkg::csr_addr_t CSR_BASE0  = 4'd4;
   localparam qa_rd_types_pkg::csr_addr_t CSR_COUNT0 = 4'd5;
   localparam int CSR_STRIDE = 2;

   // Address of the base register of stream idx
   function automatic qa_rd_types_pkg::csr_addr_t csr_base_addr(input int idx);
      return qa_rd_types_pkg::csr_addr_t'(int'(CSR_BASE0) + CSR_STRIDE * idx);
   endfunction

   // Address of the count register of stream idx
   function automatic qa_rd_types_pkg::csr_addr_t csr_count_addr(input int idx);
      return qa_rd_types_pkg::csr_addr_t'(int'(CSR_COUNT0) + CSR_STRIDE * idx);
   endfunction

endpackage

`default_nettype wire

/* design/qa_rd_types_pkg.sv */
// Typedefs for the widths of the read-request data path
// Imported by the register block, the streams, the arbiter and the top level
`default_nettype none

package qa_rd_types_pkg;

   // Host memory is addressed in whole cache lines, never in bytes
   localparam int LINE_ADDR_W  = 32;
   localparam int LINE_COUNT_W = 16;

   // A tag is the stream index on top of a per-run sequence number
   localparam int TAG_ID_W  = 2;
   localparam int TAG_SEQ_W = 6;
   localparam int RD_TAG_W  = TAG_ID_W + TAG_SEQ_W;

   // Register port widths
   localparam int CSR_ADDR_W = 4;
   localparam int CSR_DATA_W = 32;

   // One cache-line address as it goes out on the host channel
   typedef logic [LINE_ADDR_W-1:0] line_addr_t;

   // Lines left in a stream run
   typedef logic [LINE_COUNT_W-1:0] line_count_t;

   // Upper field of the tag, tells the responder which stream asked
   typedef logic [TAG_ID_W-1:0] tag_id_t;

   // Lower field of the tag; it wraps at 64 and is only unique among recent requests
   typedef logic [TAG_SEQ_W-1:0] tag_seq_t;

   // Full request tag
   typedef logic [RD_TAG_W-1:0] rd_tag_t;

   // Register address and write data
   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
   typedef logic [CSR_DATA_W-1:0] csr_data_t;

endpackage

`default_nettype wire
